// File: sources.f
conn_mgr_pkg.sv
qpn_pool.sv
conn_fsm.sv
qp_record_builder.sv
conn_mgr_top.sv
tb_clock_gen.sv
tb_conn_mgr.sv

// File: Bender.yml
package:
  name: conn_mgr

sources:
  - conn_mgr_pkg.sv
  - qpn_pool.sv
  - conn_fsm.sv
  - qp_record_builder.sv
  - conn_mgr_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_conn_mgr.sv

// File: tb_conn_mgr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conn_mgr
    import conn_mgr_pkg::*;
();

    localparam ip_addr_t CFG_IP     = 32'hc0a8_0a01;
    localparam int       WAIT_LIMIT = 50;
    // twelve transactions take under 40 cycles each and the limit leaves a wide margin
    localparam int       MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       req_valid;
    qp_info_t   req;
    logic       req_ready;
    logic       reply_valid;
    qp_info_t   reply;
    logic       reply_ready;
    logic       qp_init_valid;
    qp_init_t   qp_init;
    logic       qp_status_valid;
    logic [1:0] qp_status;
    ip_addr_t   cfg_loc_ip_addr;
    logic       known_op;

    int errors = 0;
    int test_errors = 0;
    int tests_failed = 0;
    int cycle = 0;
    int init_count = 0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) u_clock (.clk(clk), .rst(rst));

    conn_mgr_top #(.MAX_QUEUE_PAIRS(4), .FIRST_QPN(24'h100)) DUT (.*);

    assign known_op = (req.req_type == REQ_OPEN_QP) || (req.req_type == REQ_MODIFY_QP_RTS)
                      || (req.req_type == REQ_CLOSE_QP);

    hold_reply: assert property (@(posedge clk) disable iff (rst)
        reply_valid && !reply_ready |=> reply_valid && $stable(reply))
    else begin
        $display("%0t: reply changed or was dropped while reply_ready was low", $time);
        errors++;
    end

    one_in_flight: assert property (@(posedge clk) disable iff (rst)
        reply_valid |-> !req_ready)
    else begin
        $display("%0t: req_ready was high while a reply was pending", $time);
        errors++;
    end

    init_after_accept: assert property (@(posedge clk) disable iff (rst)
        qp_init_valid |-> $past(req_valid && req_ready))
    else begin
        $display("%0t: init pulse did not follow an accepted request by one cycle", $time);
        errors++;
    end

    reply_after_status: assert property (@(posedge clk) disable iff (rst)
        qp_status_valid |=> $rose(reply_valid))
    else begin
        $display("%0t: reply did not rise one cycle after the status strobe", $time);
        errors++;
    end

    drop_unknown: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && !known_op |=> req_ready && !qp_init_valid && !reply_valid)
    else begin
        $display("%0t: a request with an unknown opcode was not simply dropped", $time);
        errors++;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && qp_init_valid) begin
            init_count <= init_count + 1;
        end
    end

    function automatic qp_side_t random_side();
        qp_side_t s;
        s.r_key     = $urandom();
        s.qpn       = qpn_t'($urandom());
        s.psn       = psn_t'($urandom());
        s.ip_addr   = $urandom();
        s.base_addr = {$urandom(), $urandom()};
        return s;
    endfunction

    function automatic qp_info_t random_request(input req_type_e t);
        qp_info_t r;
        r.req_type = t;
        r.loc      = random_side();
        r.rem      = random_side();
        r.udp_port = udp_port_t'($urandom());
        return r;
    endfunction

    // the reply swaps the two sides and an open starts a fresh local side with only the new QPN
    function automatic qp_info_t build_reply(input qp_info_t r, input bit is_open, input qpn_t q);
        qp_info_t e;
        e.req_type = REQ_SEND_QP_INFO;
        if (is_open) begin
            e.loc     = '0;
            e.loc.qpn = q;
        end else begin
            e.loc = r.rem;
        end
        e.loc.ip_addr = CFG_IP;
        e.rem         = r.loc;
        e.udp_port    = r.udp_port;
        return e;
    endfunction

    function automatic qp_init_t init_model(input qp_info_t r, input bit is_open, input qpn_t q);
        qp_init_t e;
        e.req_type      = r.req_type;
        e.r_key         = r.loc.r_key;
        e.rem_qpn       = r.loc.qpn;
        e.rem_psn       = r.loc.psn;
        e.rem_ip_addr   = r.loc.ip_addr;
        e.rem_base_addr = r.loc.base_addr;
        e.loc_qpn       = is_open ? q : r.rem.qpn;
        e.loc_psn       = is_open ? psn_t'(0) : r.rem.psn;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [374:0] got,
                               input logic [374:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic present_request(input qp_info_t r);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (req_ready) else begin
            $display("%0t: request was not accepted within %0d cycles", $time, WAIT_LIMIT);
            errors++;
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic send_request(input qp_info_t r);
        present_request(r);
        wait_accept();
    endtask

    task automatic expect_init(input qp_init_t exp);
        @(negedge clk);
        assert (qp_init_valid) else begin
            $display("%0t: no init pulse one cycle after the request was accepted", $time);
            errors++;
        end
        check_value("qp_init", qp_init, exp);
    endtask

    // the queue-pair state logic answers after a random delay
    task automatic answer_status(input logic [1:0] status);
        int delay;
        delay = $urandom_range(1, 5);
        repeat (delay) @(posedge clk);
        qp_status_valid <= 1'b1;
        qp_status       <= status;
        @(posedge clk);
        qp_status_valid <= 1'b0;
    endtask

    task automatic receive_reply(input qp_info_t exp, input int hold);
        int n;
        n = 0;
        @(negedge clk);
        while (!reply_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (reply_valid) else begin
            $display("%0t: no reply arrived within %0d cycles", $time, WAIT_LIMIT);
            errors++;
        end
        check_value("reply", reply, exp);
        repeat (hold + 1) @(posedge clk);
        reply_ready <= 1'b1;
        @(posedge clk);
        reply_ready <= 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    initial begin
        qp_info_t r;
        qp_info_t exp;
        int       snap;
        req_valid       = 1'b0;
        req             = '0;
        reply_ready     = 1'b0;
        qp_status_valid = 1'b0;
        qp_status       = 2'b00;
        cfg_loc_ip_addr = CFG_IP;
        void'($urandom(32'hb578_cd88));

        do @(negedge clk); while (rst);
        check_value("req_ready", req_ready, 1'b1);
        check_value("reply_valid", reply_valid, 1'b0);
        check_value("qp_init_valid", qp_init_valid, 1'b0);
        // nothing is open yet, so the pool cannot take the QPN back
        r = random_request(REQ_CLOSE_QP);
        send_request(r);
        expect_init(init_model(r, 1'b0, '0));
        answer_status(QP_STATUS_OK);
        exp          = build_reply(r, 1'b0, '0);
        exp.req_type = REQ_ERROR;
        receive_reply(exp, $urandom_range(0, 3));
        end_test(1, "reset state and close on a full pool");

        for (int i = 0; i < 4; i++) begin
            r = random_request(REQ_OPEN_QP);
            send_request(r);
            expect_init(init_model(r, 1'b1, 24'h100 + qpn_t'(i)));
            answer_status(QP_STATUS_OK);
            exp = build_reply(r, 1'b1, 24'h100 + qpn_t'(i));
            receive_reply(exp, $urandom_range(0, 3));
        end
        snap = init_count;
        r    = random_request(REQ_OPEN_QP);
        send_request(r);
        @(negedge clk);
        check_value("reply_valid", reply_valid, 1'b1);
        exp.req_type = REQ_ERROR;
        receive_reply(exp, $urandom_range(0, 3));
        check_value("init pulses", init_count, snap);
        end_test(2, "open until the pool is empty");

        r = random_request(REQ_MODIFY_QP_RTS);
        send_request(r);
        expect_init(init_model(r, 1'b0, '0));
        answer_status(QP_STATUS_OK);
        receive_reply(build_reply(r, 1'b0, '0), $urandom_range(0, 3));
        end_test(3, "modify to RTS");

        r         = random_request(REQ_CLOSE_QP);
        r.rem.qpn = 24'h101;
        send_request(r);
        expect_init(init_model(r, 1'b0, '0));
        answer_status(QP_STATUS_OK);
        receive_reply(build_reply(r, 1'b0, '0), $urandom_range(0, 3));
        r = random_request(REQ_OPEN_QP);
        send_request(r);
        expect_init(init_model(r, 1'b1, 24'h101));
        answer_status(QP_STATUS_OK);
        receive_reply(build_reply(r, 1'b1, 24'h101), $urandom_range(0, 3));
        end_test(4, "close returns a QPN");

        r = random_request(REQ_MODIFY_QP_RTS);
        send_request(r);
        expect_init(init_model(r, 1'b0, '0));
        answer_status(2'($urandom_range(1, 3)));
        exp          = build_reply(r, 1'b0, '0);
        exp.req_type = REQ_ERROR;
        receive_reply(exp, $urandom_range(0, 3));
        end_test(5, "bad status");

        r = random_request(REQ_MODIFY_QP_RTS);
        send_request(r);
        expect_init(init_model(r, 1'b0, '0));
        answer_status(QP_STATUS_OK);
        exp = build_reply(r, 1'b0, '0);
        // the next request waits behind the pending reply
        present_request(random_request(req_type_e'(7'h2a)));
        receive_reply(exp, 6);
        snap = init_count;
        wait_accept();
        repeat (3) begin
            @(negedge clk);
            check_value("reply_valid", reply_valid, 1'b0);
        end
        check_value("init pulses", init_count, snap);
        end_test(6, "back-pressure and unknown opcode");

        $display("tests run 6, tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released on a rising edge, matching the synchronous reset of the DUT
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: conn_mgr_top.sv
`timescale 1ns/1ps
`default_nettype none

module conn_mgr_top
    import conn_mgr_pkg::*;
#(
    parameter int   MAX_QUEUE_PAIRS = 4,
    parameter qpn_t FIRST_QPN       = 24'h100
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  qp_info_t   req,
    output logic       req_ready,
    output logic       reply_valid,
    output qp_info_t   reply,
    input  logic       reply_ready,
    output logic       qp_init_valid,
    output qp_init_t   qp_init,
    input  logic       qp_status_valid,
    input  logic [1:0] qp_status,
    input  ip_addr_t   cfg_loc_ip_addr
);

    logic      pool_pop;
    logic      pool_push;
    logic      pool_empty;
    logic      pool_full;
    qpn_t      push_qpn;
    qpn_t      head_qpn;
    qpn_t      held_loc_qpn;
    logic      load;
    build_op_e op;

    qpn_pool #(
        .MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS),
        .FIRST_QPN      (FIRST_QPN)
    ) u_pool (
        .clk     (clk),
        .rst     (rst),
        .pop     (pool_pop),
        .push    (pool_push),
        .push_qpn(push_qpn),
        .head_qpn(head_qpn),
        .empty   (pool_empty),
        .full    (pool_full)
    );

    // the request stays stable while req_ready is low, so the builder samples it at load
    conn_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_type       (req.req_type),
        .req_ready      (req_ready),
        .pool_empty     (pool_empty),
        .pool_full      (pool_full),
        .pool_pop       (pool_pop),
        .pool_push      (pool_push),
        .held_loc_qpn   (held_loc_qpn),
        .push_qpn       (push_qpn),
        .qp_status_valid(qp_status_valid),
        .qp_status      (qp_status),
        .load           (load),
        .op             (op),
        .reply_valid    (reply_valid),
        .reply_ready    (reply_ready)
    );

    qp_record_builder u_builder (
        .clk            (clk),
        .rst            (rst),
        .load           (load),
        .op             (op),
        .req            (req),
        .alloc_qpn      (head_qpn),
        .cfg_loc_ip_addr(cfg_loc_ip_addr),
        .reply          (reply),
        .qp_init_valid  (qp_init_valid),
        .qp_init        (qp_init),
        .held_loc_qpn   (held_loc_qpn)
    );

endmodule

`default_nettype wire

// File: qp_record_builder.sv
`timescale 1ns/1ps
`default_nettype none

module qp_record_builder
    import conn_mgr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  build_op_e op,
    input  qp_info_t  req,
    input  qpn_t      alloc_qpn,
    input  ip_addr_t  cfg_loc_ip_addr,
    output qp_info_t  reply,
    output logic      qp_init_valid,
    output qp_init_t  qp_init,
    output qpn_t      held_loc_qpn
);

    qp_side_t open_loc;
    qp_side_t swap_loc;
    qp_init_t init_next;
    qp_info_t reply_reg;
    qp_init_t init_reg;
    logic     init_valid_reg;

    // the local side of the reply is fresh for an open and mirrored from the request otherwise
    always_comb begin
        open_loc         = '0;
        open_loc.qpn     = alloc_qpn;
        open_loc.ip_addr = cfg_loc_ip_addr;

        swap_loc         = req.rem;
        swap_loc.ip_addr = cfg_loc_ip_addr;
    end

    always_comb begin
        init_next.req_type      = req.req_type;
        init_next.r_key         = req.loc.r_key;
        init_next.rem_qpn       = req.loc.qpn;
        init_next.rem_psn       = req.loc.psn;
        init_next.rem_ip_addr   = req.loc.ip_addr;
        init_next.rem_base_addr = req.loc.base_addr;
        if (op == BUILD_OPEN) begin
            init_next.loc_qpn = alloc_qpn;
            init_next.loc_psn = '0;
        end else begin
            init_next.loc_qpn = req.rem.qpn;
            init_next.loc_psn = req.rem.psn;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            case (op)
                BUILD_OPEN, BUILD_SWAP: begin
                    reply_reg.req_type <= REQ_SEND_QP_INFO;
                    reply_reg.loc      <= (op == BUILD_OPEN) ? open_loc : swap_loc;
                    reply_reg.rem      <= req.loc;
                    reply_reg.udp_port <= req.udp_port;
                    init_reg           <= init_next;
                end
                default: begin
                    // an error keeps the rest of the reply as it was
                    reply_reg.req_type <= REQ_ERROR;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init_valid_reg <= 1'b0;
        end else begin
            init_valid_reg <= load && (op == BUILD_OPEN || op == BUILD_SWAP);
        end
    end

    assign reply         = reply_reg;
    assign qp_init       = init_reg;
    assign qp_init_valid = init_valid_reg;
    assign held_loc_qpn  = init_reg.loc_qpn;

endmodule

`default_nettype wire

// File: conn_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module conn_fsm
    import conn_mgr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  req_type_e  req_type,
    output logic       req_ready,
    input  logic       pool_empty,
    input  logic       pool_full,
    output logic       pool_pop,
    output logic       pool_push,
    input  qpn_t       held_loc_qpn,
    output qpn_t       push_qpn,
    input  logic       qp_status_valid,
    input  logic [1:0] qp_status,
    output logic       load,
    output build_op_e  op,
    output logic       reply_valid,
    input  logic       reply_ready
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_STATUS,
        REPLY
    } state_e;

    state_e state;
    state_e state_next;
    logic   close_flag;
    logic   close_next;

    assign req_ready   = (state == IDLE);
    assign reply_valid = (state == REPLY);

    // a close hands the QPN from the init record back to the pool
    assign push_qpn = held_loc_qpn;

    always_comb begin
        state_next = state;
        close_next = close_flag;
        pool_pop   = 1'b0;
        pool_push  = 1'b0;
        load       = 1'b0;
        op         = BUILD_OPEN;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    case (req_type)
                        REQ_OPEN_QP: begin
                            load       = 1'b1;
                            close_next = 1'b0;
                            if (pool_empty) begin
                                op         = BUILD_ERROR;
                                state_next = REPLY;
                            end else begin
                                pool_pop   = 1'b1;
                                op         = BUILD_OPEN;
                                state_next = WAIT_STATUS;
                            end
                        end
                        REQ_MODIFY_QP_RTS, REQ_CLOSE_QP: begin
                            load       = 1'b1;
                            op         = BUILD_SWAP;
                            close_next = (req_type == REQ_CLOSE_QP);
                            state_next = WAIT_STATUS;
                        end
                        default: begin
                            // anything else is dropped without a reply
                            state_next = IDLE;
                        end
                    endcase
                end
            end
            WAIT_STATUS: begin
                if (qp_status_valid) begin
                    state_next = REPLY;
                    if (qp_status != QP_STATUS_OK || (close_flag && pool_full)) begin
                        load = 1'b1;
                        op   = BUILD_ERROR;
                    end else if (close_flag) begin
                        pool_push = 1'b1;
                    end
                end
            end
            REPLY: begin
                if (reply_ready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            close_flag <= 1'b0;
        end else begin
            state      <= state_next;
            close_flag <= close_next;
        end
    end

endmodule

`default_nettype wire

// File: qpn_pool.sv
`timescale 1ns/1ps
`default_nettype none

module qpn_pool
    import conn_mgr_pkg::*;
#(
    parameter int   MAX_QUEUE_PAIRS = 4,
    parameter qpn_t FIRST_QPN       = 24'h100
) (
    input  logic clk,
    input  logic rst,
    input  logic pop,
    input  logic push,
    input  qpn_t push_qpn,
    output qpn_t head_qpn,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (MAX_QUEUE_PAIRS > 1) ? $clog2(MAX_QUEUE_PAIRS) : 1;
    localparam int CNT_W = $clog2(MAX_QUEUE_PAIRS + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_QUEUE_PAIRS - 1);

    qpn_t             mem [MAX_QUEUE_PAIRS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             do_push;

    assign do_pop  = pop && !empty;
    assign do_push = push && !full;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(MAX_QUEUE_PAIRS));
    assign head_qpn = mem[rd_ptr];

    // the pool starts full, so the write pointer wraps back onto entry zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MAX_QUEUE_PAIRS; i++) begin
                mem[i] <= FIRST_QPN + qpn_t'(i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_W'(MAX_QUEUE_PAIRS);
        end else begin
            if (do_push) begin
                mem[wr_ptr] <= push_qpn;
                wr_ptr      <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: conn_mgr_pkg.sv
`default_nettype none

package conn_mgr_pkg;

    typedef logic [23:0] qpn_t;
    typedef logic [23:0] psn_t;
    typedef logic [31:0] rkey_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [63:0] base_addr_t;
    typedef logic [15:0] udp_port_t;

    // opcodes carried in the req_type field of requests, replies and init records
    typedef enum logic [6:0] {
        REQ_NULL          = 7'd0,
        REQ_OPEN_QP       = 7'd1,
        REQ_SEND_QP_INFO  = 7'd2,
        REQ_MODIFY_QP_RTS = 7'd3,
        REQ_CLOSE_QP      = 7'd4,
        REQ_ERROR         = 7'd5
    } req_type_e;

    // what the record builder loads on a load strobe
    typedef enum logic [1:0] {
        BUILD_OPEN  = 2'd0,
        BUILD_SWAP  = 2'd1,
        BUILD_ERROR = 2'd2
    } build_op_e;

    // one end of a connection
    typedef struct packed {
        rkey_t      r_key;
        qpn_t       qpn;
        psn_t       psn;
        ip_addr_t   ip_addr;
        base_addr_t base_addr;
    } qp_side_t;

    // in a request udp_port is the peer's listening port, in a reply the destination port
    typedef struct packed {
        req_type_e req_type;
        qp_side_t  loc;
        qp_side_t  rem;
        udp_port_t udp_port;
    } qp_info_t;

    // record handed to the queue-pair state logic
    typedef struct packed {
        req_type_e  req_type;
        rkey_t      r_key;
        qpn_t       rem_qpn;
        qpn_t       loc_qpn;
        psn_t       rem_psn;
        psn_t       loc_psn;
        ip_addr_t   rem_ip_addr;
        base_addr_t rem_base_addr;
    } qp_init_t;

    localparam logic [1:0] QP_STATUS_OK = 2'b00;

endpackage

`default_nettype wire
